//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = slowVramTb
FILELIST  = slowVram.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Some tests failed
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/cpuPort.sv
`timescale 1ns/100ps
`default_nettype none

module cpuPort
(
	input wire CLK_24M,
	input wire arstN,
	input wire slowVramPkg::cpuReqS cpuReq,
	input wire cpuReqValid,
	input wire cpuZone,
	output logic cpuBusy,
	output logic cpuDone,
	output logic [15:0] cpuRdData,
	output slowVramPkg::cpuReqS heldReq,
	output logic cpuPending,
	input wire cpuServed,
	input wire [15:0] cpuRdWord
);

	// Strobe taken only for the slow zone and only when idle
	logic accept;

	// Zone high means fast VRAM, handled elsewhere
	// A strobe while busy is lost
	assign accept = cpuReqValid && !cpuZone && !cpuBusy;

	// Busy is set on capture and cleared when the sequencer serves it
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			cpuBusy <= 1'b0;
			cpuDone <= 1'b0;
		end
		else
		begin
			// Done follows the served pulse by one cycle
			cpuDone <= cpuServed;
			if (cpuServed)
				cpuBusy <= 1'b0;
			else if (accept)
				cpuBusy <= 1'b1;
		end
	end

	// Request held until the CPU slot picks it up
	always_ff @(posedge CLK_24M)
	begin
		if (accept)
			heldReq <= cpuReq;
	end

	// Read word kept for the CPU, valid with cpuDone
	always_ff @(posedge CLK_24M)
	begin
		if (cpuServed && (heldReq.op == slowVramPkg::CPU_READ))
			cpuRdData <= cpuRdWord;
	end

	// Sequencer sees the held request as long as it is not served
	assign cpuPending = cpuBusy;

endmodule

`default_nettype wire

//--- rtl/slowCycle.sv
`timescale 1ns/100ps
`default_nettype none

`include "slowVram_macros.svh"

module slowCycle
(
	input wire CLK_24M,
	input wire arstN,
	input wire hSync,
	input wire [8:0] hCount,
	input wire [8:0] vCount,
	input wire [8:0] sprNb,
	input wire [4:0] sprTileIdx,
	input wire slowVramPkg::cpuReqS heldReq,
	input wire cpuPending,
	output logic cpuServed,
	output logic [15:0] cpuRdWord,
	output slowVramPkg::vramBusS bus,
	input wire [15:0] rdData,
	output slowVramPkg::fixAttrS fixAttr,
	output slowVramPkg::sprAttrS sprAttr
);

	localparam int CNT_W = $clog2(`SV_SLOT_CYCLES);

	// Slot cycles where something happens
	localparam logic [CNT_W-1:0] CYC_FIX_LATCH = CNT_W'(1);
	localparam logic [CNT_W-1:0] CYC_CPU_WE = CNT_W'(2);
	localparam logic [CNT_W-1:0] CYC_CPU_LATE = CNT_W'(3);
	localparam logic [CNT_W-1:0] CYC_CPU_DONE = CNT_W'(5);
	localparam logic [CNT_W-1:0] CYC_EVEN_LATCH = CNT_W'(9);
	localparam logic [CNT_W-1:0] CYC_ODD_LATCH = CNT_W'(13);

	// Slot cycle, 0 right after hSync
	logic [CNT_W-1:0] slotCnt;
	// Shifted by two so each slot is one aligned group of four
	logic [CNT_W-1:0] slotIdx;
	slowVramPkg::slotE slot;
	// Fix column fetched ahead of the one being drawn
	logic [8:0] nextCol;
	logic [14:0] fixAddr;
	// Sprite word pair base, LSB picks even or odd
	logic [13:0] sprBase;
	// CPU request taken in this frame's CPU slot
	logic cpuGrant;
	// Even sprite word held until the odd one arrives
	logic [15:0] sprLow;

	// Free-running slot counter, realigned on every line
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
			slotCnt <= '0;
		else if (hSync)
			slotCnt <= '0;
		else
			slotCnt <= slotCnt + CNT_W'(1);
	end

	// 14,15,0,1 fix / 2-5 CPU / 6-9 even / 10-13 odd
	assign slotIdx = slotCnt + CNT_W'(2);
	assign slot = slowVramPkg::slotE'(slotIdx[CNT_W-1:CNT_W-2]);

	// Column after the current one, wraps at the line end
	assign nextCol = (hCount == 9'(`SV_LINE_PIXELS - 1)) ? 9'd0 : hCount + 9'd1;
	// Fix map is column major, 32 rows per column
	assign fixAddr = {`SV_FIX_BASE, nextCol[8:3], vCount[7:3]};
	assign sprBase = {sprNb, sprTileIdx};

	// VRAM address mux
	always_comb
	begin
		bus.addr = fixAddr;
		bus.wrData = heldReq.wrData;
		bus.we = 1'b0;
		case (slot)
			slowVramPkg::SLOT_FIX:
			begin
				bus.addr = fixAddr;
			end
			slowVramPkg::SLOT_CPU:
			begin
				bus.addr = heldReq.addr;
				// Single write strobe at the start of the slot
				bus.we = (slotCnt == CYC_CPU_WE) && cpuPending &&
					(heldReq.op == slowVramPkg::CPU_WRITE);
			end
			slowVramPkg::SLOT_SPR_EVEN:
			begin
				bus.addr = {sprBase, 1'b0};
			end
			default:
			begin
				bus.addr = {sprBase, 1'b1};
			end
		endcase
	end

	// Decide whether the CPU slot carries a request
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
			cpuGrant <= 1'b0;
		else if (slotCnt == CYC_CPU_WE)
			cpuGrant <= cpuPending;
		// Late reads still have two address cycles left
		else if ((slotCnt == CYC_CPU_LATE) && cpuPending &&
			(heldReq.op == slowVramPkg::CPU_READ))
			cpuGrant <= 1'b1;
		else if (slotCnt == CYC_CPU_DONE)
			cpuGrant <= 1'b0;
	end

	// Idle CPU slot gives no served pulse
	assign cpuServed = (slotCnt == CYC_CPU_DONE) && cpuGrant;
	// Data from the address of cycle 4
	assign cpuRdWord = rdData;

	// Even word, low 16 bits of the sprite tile number
	always_ff @(posedge CLK_24M)
	begin
		if (slotCnt == CYC_EVEN_LATCH)
			sprLow <= rdData;
	end

	// Attribute registers
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			fixAttr <= '0;
			sprAttr <= '0;
		end
		else
		begin
			if (slotCnt == CYC_FIX_LATCH)
			begin
				fixAttr.tileNb <= rdData[11:0];
				fixAttr.pal <= rdData[15:12];
			end
			// Both words published together, never half a pair
			if (slotCnt == CYC_ODD_LATCH)
			begin
				sprAttr.tileNb <= {rdData[7:4], sprLow};
				sprAttr.pal <= rdData[15:8];
				sprAttr.aa <= rdData[3:2];
				sprAttr.flip <= rdData[1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/slowVramPkg.sv
`default_nettype none

package slowVramPkg;

	// Slot owners, in the order they appear in a slot frame
	// Encoding follows (slot cycle + 2) / 4
	typedef enum logic [1:0]
	{
		SLOT_FIX,
		SLOT_CPU,
		SLOT_SPR_EVEN,
		SLOT_SPR_ODD
	} slotE;

	// CPU access direction
	typedef enum logic
	{
		CPU_READ,
		CPU_WRITE
	} cpuOpE;

	// One CPU request as seen on the slow VRAM side
	typedef struct packed
	{
		logic [14:0] addr;
		logic [15:0] wrData;
		cpuOpE op;
	} cpuReqS;

	// Single-port VRAM bus, address and write data share one cycle
	typedef struct packed
	{
		logic [14:0] addr;
		logic [15:0] wrData;
		logic we;
	} vramBusS;

	// Fix tile attributes for the next 8-pixel column
	typedef struct packed
	{
		logic [11:0] tileNb;
		logic [3:0] pal;
	} fixAttrS;

	// Sprite tile attributes built from the even and odd words
	typedef struct packed
	{
		logic [19:0] tileNb;
		logic [7:0] pal;
		logic [1:0] aa;
		logic [1:0] flip;
	} sprAttrS;

endpackage

`default_nettype wire

//--- rtl/slowVramTop.sv
`timescale 1ns/100ps
`default_nettype none

module slowVramTop
(
	input wire CLK_24M,
	input wire arstN,
	input wire [8:0] sprNb,
	input wire [4:0] sprTileIdx,
	input wire slowVramPkg::cpuReqS cpuReq,
	input wire cpuReqValid,
	input wire cpuZone,
	output logic cpuBusy,
	output logic cpuDone,
	output logic [15:0] cpuRdData,
	output slowVramPkg::fixAttrS fixAttr,
	output slowVramPkg::sprAttrS sprAttr,
	output logic [8:0] hCount,
	output logic [8:0] vCount,
	output logic hSync
);

	// CPU port to sequencer
	slowVramPkg::cpuReqS heldReq;
	logic cpuPending;
	logic cpuServed;
	logic [15:0] cpuRdWord;

	// Sequencer to VRAM
	slowVramPkg::vramBusS vramBus;
	logic [15:0] vramRdData;

	// Raster counters and line sync
	videoTiming uTiming
	(
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.hCount(hCount),
		.vCount(vCount),
		.hSync(hSync)
	);

	// CPU request capture and read return
	cpuPort uCpuPort
	(
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.cpuReq(cpuReq),
		.cpuReqValid(cpuReqValid),
		.cpuZone(cpuZone),
		.cpuBusy(cpuBusy),
		.cpuDone(cpuDone),
		.cpuRdData(cpuRdData),
		.heldReq(heldReq),
		.cpuPending(cpuPending),
		.cpuServed(cpuServed),
		.cpuRdWord(cpuRdWord)
	);

	// Slot sequencer
	slowCycle uSlowCycle
	(
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.hSync(hSync),
		.hCount(hCount),
		.vCount(vCount),
		.sprNb(sprNb),
		.sprTileIdx(sprTileIdx),
		.heldReq(heldReq),
		.cpuPending(cpuPending),
		.cpuServed(cpuServed),
		.cpuRdWord(cpuRdWord),
		.bus(vramBus),
		.rdData(vramRdData),
		.fixAttr(fixAttr),
		.sprAttr(sprAttr)
	);

	// Slow VRAM array
	vramSlow uVram
	(
		.CLK_24M(CLK_24M),
		.bus(vramBus),
		.rdData(vramRdData)
	);

endmodule

`default_nettype wire

//--- rtl/slowVram_macros.svh
`ifndef SLOW_VRAM_MACROS_SVH
`define SLOW_VRAM_MACROS_SVH

// CLK_24M cycles in one slow VRAM slot frame
// Four clients, four cycles each
`define SV_SLOT_CYCLES 16

// CLK_24M cycles per pixel
`define SV_PIXEL_DIV 4

// Pixel counts per line, 48 fix columns of 8 pixels
`define SV_LINE_PIXELS 384

// Lines per frame
`define SV_LINE_COUNT 264

// Slow VRAM depth in 16-bit words
`define SV_VRAM_WORDS 32768

// Upper address bits of the fix map, giving the 7000h region
`define SV_FIX_BASE 4'b1110

`endif

//--- rtl/videoTiming.sv
`timescale 1ns/100ps
`default_nettype none

`include "slowVram_macros.svh"

module videoTiming
(
	input wire CLK_24M,
	input wire arstN,
	output logic [8:0] hCount,
	output logic [8:0] vCount,
	output logic hSync
);

	localparam int DIV_W = $clog2(`SV_PIXEL_DIV);

	// Pixel clock divider phase
	logic [DIV_W-1:0] pixDiv;
	// High in the last CLK_24M cycle of a pixel
	logic pixStep;
	// High in the last CLK_24M cycle of a line
	logic lineEnd;

	assign pixStep = (pixDiv == DIV_W'(`SV_PIXEL_DIV - 1));
	assign lineEnd = pixStep && (hCount == 9'(`SV_LINE_PIXELS - 1));

	// Divide CLK_24M down to the pixel rate
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
			pixDiv <= '0;
		else if (pixStep)
			pixDiv <= '0;
		else
			pixDiv <= pixDiv + DIV_W'(1);
	end

	// Pixel counter, wraps at the end of the line
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
			hCount <= '0;
		else if (lineEnd)
			hCount <= '0;
		else if (pixStep)
			hCount <= hCount + 9'd1;
	end

	// Line counter, steps once per line
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
			vCount <= '0;
		else if (lineEnd)
		begin
			if (vCount == 9'(`SV_LINE_COUNT - 1))
				vCount <= '0;
			else
				vCount <= vCount + 9'd1;
		end
	end

	// One cycle wide, restarts the slot frame
	assign hSync = lineEnd;

endmodule

`default_nettype wire

//--- rtl/vramSlow.sv
`timescale 1ns/100ps
`default_nettype none

`include "slowVram_macros.svh"

module vramSlow
(
	input wire CLK_24M,
	input wire slowVramPkg::vramBusS bus,
	output logic [15:0] rdData
);

	// Word array, upper and lower bytes written together
	logic [15:0] mem [`SV_VRAM_WORDS];

	// Single port, one access per cycle
	// Read data appears one cycle after the address
	always_ff @(posedge CLK_24M)
	begin
		if (bus.we)
		begin
			mem[bus.addr] <= bus.wrData;
			// Write-first, the new word is returned
			rdData <= bus.wrData;
		end
		else
		begin
			rdData <= mem[bus.addr];
		end
	end

endmodule

`default_nettype wire

//--- sim/slowVramTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "slowVram_macros.svh"

module slowVramTb;

	// CLK_24M cycles per raster line
	localparam int LINE_CYC = `SV_LINE_PIXELS * `SV_PIXEL_DIV;
	// Longest CPU latency is one full slot frame plus a few cycles
	localparam int DONE_WAIT = 2 * `SV_SLOT_CYCLES + 8;
	// Six lines of traffic plus margin
	localparam int WDOG_CYC = 6 * LINE_CYC + 512;

	logic CLK_24M;
	logic arstN;
	logic [8:0] sprNb;
	logic [4:0] sprTileIdx;
	slowVramPkg::cpuReqS cpuReq;
	logic cpuReqValid;
	logic cpuZone;
	logic cpuBusy;
	logic cpuDone;
	logic [15:0] cpuRdData;
	slowVramPkg::fixAttrS fixAttr;
	slowVramPkg::sprAttrS sprAttr;
	logic [8:0] hCount;
	logic [8:0] vCount;
	logic hSync;

	// Mirror of every word written through the slow port
	logic [15:0] shadow [`SV_VRAM_WORDS];
	integer seed;
	int errCount;
	int doneCount;
	// Cycle index since reset release, the raster starts from the same point
	int cycleNo;
	logic [15:0] rdWord;
	logic [14:0] addr;
	logic [15:0] data;
	logic [8:0] nb;
	logic [4:0] idx;
	int hPix;
	int line;

	slowVramTop DUT (.*);

	initial
	begin
		CLK_24M = 1'b0;
		forever
			#20 CLK_24M = ~CLK_24M;
	end

	// Same reset behavior as the raster counters
	always @(posedge CLK_24M)
	begin
		if (!arstN)
			cycleNo <= 0;
		else
			cycleNo <= cycleNo + 1;
	end

	// Line sync expected in the last cycle of every line, done pulses counted
	always @(negedge CLK_24M)
	begin
		if (arstN)
		begin
			checkBit("hSync", hSync, (cycleNo % LINE_CYC) == LINE_CYC - 1);
			if (cpuDone)
				doneCount <= doneCount + 1;
		end
	end

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errCount++;
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
		begin
			errCount++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkFix(input slowVramPkg::fixAttrS got, input slowVramPkg::fixAttrS exp);
		if (got !== exp)
		begin
			errCount++;
			$display("MISMATCH at %0t: fixAttr got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic checkSpr(input slowVramPkg::sprAttrS got, input slowVramPkg::sprAttrS exp);
		if (got !== exp)
		begin
			errCount++;
			$display("MISMATCH at %0t: sprAttr got %h expected %h", $time, got, exp);
		end
	endtask

	// Fix map entry for the column after hPix on the given line
	function automatic logic [14:0] fixAddrOf(input int hPix, input int line);
		int nextCol;
		logic [8:0] col;
		logic [8:0] row;
		nextCol = (hPix == `SV_LINE_PIXELS - 1) ? 0 : hPix + 1;
		col = 9'(nextCol);
		row = 9'(line);
		return {`SV_FIX_BASE, col[8:3], row[7:3]};
	endfunction

	function automatic slowVramPkg::fixAttrS fixRef(input logic [14:0] addr);
		slowVramPkg::fixAttrS attr;
		attr.tileNb = shadow[addr][11:0];
		attr.pal = shadow[addr][15:12];
		return attr;
	endfunction

	function automatic logic [14:0] sprAddrOf(input logic [8:0] nb, input logic [4:0] idx,
		input logic odd);
		return {nb, idx, odd};
	endfunction

	// Tile number low half from the even word, everything else from the odd word
	function automatic slowVramPkg::sprAttrS sprRef(input logic [8:0] nb, input logic [4:0] idx);
		slowVramPkg::sprAttrS attr;
		logic [15:0] even;
		logic [15:0] odd;
		even = shadow[sprAddrOf(nb, idx, 1'b0)];
		odd = shadow[sprAddrOf(nb, idx, 1'b1)];
		attr.tileNb = {odd[7:4], even};
		attr.pal = odd[15:8];
		attr.aa = odd[3:2];
		attr.flip = odd[1:0];
		return attr;
	endfunction

	// Stops at the next negedge whose cycle index hits the given phase
	task automatic waitPhase(input int period, input int phase);
		@(negedge CLK_24M);
		while ((cycleNo % period) != phase)
			@(negedge CLK_24M);
	endtask

	// One slow zone access, waits for its single done pulse
	task automatic cpuAccess(input slowVramPkg::cpuOpE op, input logic [14:0] addr,
		input logic [15:0] data, output logic [15:0] rdWord);
		slowVramPkg::cpuReqS req;
		int startCount;
		int waitCyc;
		req.addr = addr;
		req.wrData = data;
		req.op = op;
		rdWord = '0;
		@(posedge CLK_24M);
		cpuReq <= req;
		cpuReqValid <= 1'b1;
		cpuZone <= 1'b0;
		@(posedge CLK_24M);
		cpuReqValid <= 1'b0;
		@(negedge CLK_24M);
		startCount = doneCount;
		checkBit("cpuBusy", cpuBusy, 1'b1);
		waitCyc = 0;
		while (!cpuDone && (waitCyc < DONE_WAIT))
		begin
			@(negedge CLK_24M);
			waitCyc++;
		end
		if (!cpuDone)
		begin
			errCount++;
			$display("ERROR at %0t: no cpuDone for the request to address %h", $time, addr);
		end
		else
		begin
			rdWord = cpuRdData;
			if (op == slowVramPkg::CPU_WRITE)
				shadow[addr] = data;
			repeat (2) @(negedge CLK_24M);
			if (doneCount != startCount + 1)
			begin
				errCount++;
				$display("ERROR at %0t: %0d cpuDone pulses for one request to address %h",
					$time, doneCount - startCount, addr);
			end
		end
	endtask

	// Fast zone strobe, the slow port must not react
	task automatic fastZoneWrite(input logic [14:0] addr, input logic [15:0] data);
		slowVramPkg::cpuReqS req;
		int startCount;
		logic busySeen;
		req.addr = addr;
		req.wrData = data;
		req.op = slowVramPkg::CPU_WRITE;
		busySeen = 1'b0;
		@(posedge CLK_24M);
		cpuReq <= req;
		cpuReqValid <= 1'b1;
		cpuZone <= 1'b1;
		@(posedge CLK_24M);
		cpuReqValid <= 1'b0;
		cpuZone <= 1'b0;
		@(negedge CLK_24M);
		startCount = doneCount;
		repeat (DONE_WAIT)
		begin
			busySeen = busySeen | cpuBusy;
			@(negedge CLK_24M);
		end
		if (busySeen || (doneCount != startCount))
		begin
			errCount++;
			$display("ERROR at %0t: fast zone request was taken by the slow port", $time);
		end
	endtask

	initial
	begin
		seed = 32'h697c_f319;
		arstN = 1'b0;
		sprNb = '0;
		sprTileIdx = '0;
		cpuReq = '0;
		cpuReqValid = 1'b0;
		cpuZone = 1'b0;
		repeat (16) @(posedge CLK_24M);
		arstN <= 1'b1;

		// Reset values in the first cycle after release
		@(negedge CLK_24M);
		checkBit("cpuBusy", cpuBusy, 1'b0);
		checkBit("cpuDone", cpuDone, 1'b0);
		checkFix(fixAttr, '0);
		checkSpr(sprAttr, '0);

		// Write then read back random addresses
		for (int i = 0; i < 8; i++)
		begin
			addr = 15'($random(seed));
			data = 16'($random(seed));
			cpuAccess(slowVramPkg::CPU_WRITE, addr, data, rdWord);
			cpuAccess(slowVramPkg::CPU_READ, addr, 16'h0000, rdWord);
			checkWord("cpuRdData", rdWord, shadow[addr]);
		end

		// Fast zone write to the last address leaves it unchanged
		fastZoneWrite(addr, ~shadow[addr]);
		cpuAccess(slowVramPkg::CPU_READ, addr, 16'h0000, rdWord);
		checkWord("cpuRdData", rdWord, shadow[addr]);

		// Fill fix row 0 for every column
		// Test lines all fall in fix row 0
		for (int col = 0; col < `SV_LINE_PIXELS / 8; col++)
		begin
			addr = {`SV_FIX_BASE, 6'(col), 5'd0};
			cpuAccess(slowVramPkg::CPU_WRITE, addr, 16'($random(seed)), rdWord);
		end

		// Every slot frame of the next line, sampled at slot cycle 2
		for (int k = 0; k < LINE_CYC / `SV_SLOT_CYCLES; k++)
		begin
			waitPhase(LINE_CYC, k * `SV_SLOT_CYCLES + 2);
			hPix = (cycleNo % LINE_CYC) / `SV_PIXEL_DIV;
			line = (cycleNo / LINE_CYC) % `SV_LINE_COUNT;
			checkWord("hCount", {7'd0, hCount}, 16'(hPix));
			checkWord("vCount", {7'd0, vCount}, 16'(line));
			checkFix(fixAttr, fixRef(fixAddrOf(hPix, line)));
		end

		// Random sprite words, inputs held over a whole frame
		for (int i = 0; i < 6; i++)
		begin
			nb = 9'($random(seed));
			idx = 5'($random(seed));
			cpuAccess(slowVramPkg::CPU_WRITE, sprAddrOf(nb, idx, 1'b0), 16'($random(seed)), rdWord);
			cpuAccess(slowVramPkg::CPU_WRITE, sprAddrOf(nb, idx, 1'b1), 16'($random(seed)), rdWord);
			@(posedge CLK_24M);
			sprNb <= nb;
			sprTileIdx <= idx;
			waitPhase(`SV_SLOT_CYCLES, 5);
			waitPhase(`SV_SLOT_CYCLES, 14);
			checkSpr(sprAttr, sprRef(nb, idx));
		end

		$display("Summary: %0d errors, %0d cpuDone pulses", errCount, doneCount);
		if (errCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Run length bound
	initial
	begin
		repeat (WDOG_CYC) @(posedge CLK_24M);
		errCount++;
		$display("ERROR at %0t: watchdog expired before the test sequence finished", $time);
		$display("Summary: %0d errors, %0d cpuDone pulses", errCount, doneCount);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/slowVram_chk.sv
`timescale 1ns/100ps
`default_nettype none

module slowVramChk
(
	input wire CLK_24M,
	input wire arstN,
	input wire hSync,
	input wire [3:0] slotCnt,
	input wire slowVramPkg::vramBusS bus,
	input wire cpuServed
);

	// First cycle of the CPU slot
	localparam logic [3:0] CPU_WE_CYC = 4'd2;

	// CPU write strobe only at the start of the CPU slot
	weInCpuSlot: assert property (@(posedge CLK_24M) disable iff (!arstN)
		bus.we |-> (slotCnt == CPU_WE_CYC))
		else $error("VRAM write enable outside slot cycle 2");

	// Served is a single-cycle pulse
	servedOneCycle: assert property (@(posedge CLK_24M) disable iff (!arstN)
		cpuServed |=> !cpuServed)
		else $error("cpuServed high for more than one cycle");

	// Line sync restarts the slot frame
	slotRestart: assert property (@(posedge CLK_24M) disable iff (!arstN)
		hSync |=> (slotCnt == 4'd0))
		else $error("slot counter not zero in the cycle after hSync");

endmodule

bind slowCycle slowVramChk uChk
(
	.CLK_24M(CLK_24M),
	.arstN(arstN),
	.hSync(hSync),
	.slotCnt(slotCnt),
	.bus(bus),
	.cpuServed(cpuServed)
);

`default_nettype wire

//--- slowVram.f
+incdir+rtl
rtl/slowVramPkg.sv
rtl/videoTiming.sv
rtl/cpuPort.sv
rtl/vramSlow.sv
rtl/slowCycle.sv
rtl/slowVramTop.sv
sim/slowVram_chk.sv
sim/slowVramTb.sv
